/* memcpy_consts.svh */
`ifndef MEMCPY_CONSTS_SVH
`define MEMCPY_CONSTS_SVH

// ========================================
// address and data widths
// ========================================
`define MEMCPY_ADDR_W      64
`define MEMCPY_DATA_W      64

// ========================================
// line and page geometry
// ========================================
`define MEMCPY_LINE_BYTES  64
`define MEMCPY_LINE_SHIFT  6
`define MEMCPY_PAGE_BYTES  4096
`define MEMCPY_PAGE_SHIFT  12
// one page holds this many lines, so no burst is longer.
`define MEMCPY_MAX_BURST   64

// ========================================
// queue depths
// ========================================
`define MEMCPY_CMD_DEPTH   4
// room for two whole bursts.
`define MEMCPY_LINE_DEPTH  128

`endif

/* memcpy_pkg.sv */
`include "memcpy_consts.svh"

package memcpy_pkg;

   // one copy request as software queues it.
   typedef struct packed
   {
      logic [`MEMCPY_ADDR_W-1:0] addr;
      logic [`MEMCPY_ADDR_W-1:0] len;
   } copy_cmd_t;

   // a line-aligned read burst; lines runs from 1 to 64.
   typedef struct packed
   {
      logic [`MEMCPY_ADDR_W-1:0] addr;
      logic [7:0]                lines;
   } burst_req_t;

   // one returned beat together with the address of its line.
   typedef struct packed
   {
      logic [`MEMCPY_ADDR_W-1:0] addr;
      logic [`MEMCPY_DATA_W-1:0] data;
   } line_t;

endpackage

/* memcpy_sync_fifo.sv */
module memcpy_sync_fifo #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 4
) (
   input  logic                                      clk,
   input  logic                                      rst_n,
   input  logic                                      push,
   input  payload_t                                  wdata,
   input  logic                                      pop,
   output payload_t                                  rdata,
   output logic                                      empty,
   output logic                                      full,
   output logic [((DEPTH > 1) ? $clog2(DEPTH) : 1):0] free
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             do_push;
   logic             do_pop;

   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   assign empty = (count == '0);
   assign full  = (count == (PTR_W+1)'(DEPTH));
   assign free  = (PTR_W+1)'(DEPTH) - count;
   assign rdata = mem[rd_ptr];

   // the array is written at the tail and read at the head.
   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= wdata;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // ========================================
   // checks
   // ========================================
   // a push into a full FIFO or a pop from an empty one is a caller error.
   a_no_overflow: assert property (
      @(posedge clk) disable iff (!rst_n)
      push |-> !full
   ) else $error("fifo push while full");

   a_no_underflow: assert property (
      @(posedge clk) disable iff (!rst_n)
      pop |-> !empty
   ) else $error("fifo pop while empty");

endmodule

/* memcpy_burst_planner.sv */
`include "memcpy_consts.svh"

module memcpy_burst_planner (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   cmd_empty,
   input  memcpy_pkg::copy_cmd_t  cmd,
   output logic                   cmd_pop,
   input  logic                   buf_busy,
   output logic                   burst_start,
   output memcpy_pkg::burst_req_t burst,
   input  logic                   burst_done,
   output logic                   copy_done
);

   localparam int AW = `MEMCPY_ADDR_W;
   localparam int LS = `MEMCPY_LINE_SHIFT;
   localparam int PS = `MEMCPY_PAGE_SHIFT;

   typedef enum logic [2:0]
   {
      IDLE,
      INIT,
      PAGE,
      SIZE,
      START,
      BUSY,
      DONE
   } state_t;

   state_t                state;
   state_t                state_nxt;
   memcpy_pkg::copy_cmd_t cmd_q;
   logic [AW-1:0]         end_addr;
   logic [AW-1:0]         cur_addr;
   logic [AW-1:0]         next_page;
   logic [AW-1:0]         end_page;
   logic [AW-1:0]         end_line;
   logic [AW-1:0]         line_span;
   logic [7:0]            cur_lines;
   logic                  last_burst;
   logic                  beyond_page;
   logic [AW-1:0]         burst_last_line;

   // ========================================
   // FSM
   // ========================================
   always_comb
   begin
      state_nxt = state;
      case (state)
         IDLE:    if (!cmd_empty) state_nxt = INIT;
         INIT:    state_nxt = (cmd_q.len == '0) ? IDLE : PAGE;
         PAGE:    state_nxt = SIZE;
         SIZE:    if (!buf_busy) state_nxt = START;
         START:   state_nxt = BUSY;
         BUSY:    if (burst_done) state_nxt = DONE;
         DONE:    state_nxt = last_burst ? IDLE : PAGE;
         default: state_nxt = IDLE;
      endcase
   end

   assign cmd_pop   = (state == IDLE) && !cmd_empty;
   assign copy_done = (state == IDLE) && cmd_empty;

   // the end is past this page only if its page-rounded value is too.
   assign beyond_page = (end_page > next_page);
   assign line_span   = end_line - cur_addr;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state       <= IDLE;
         burst_start <= 1'b0;
         last_burst  <= 1'b0;
      end
      else
      begin
         state       <= state_nxt;
         burst_start <= (state == START);
         if (state == SIZE)
            last_burst <= !beyond_page;
      end
   end

   // ========================================
   // burst arithmetic
   // ========================================
   always_ff @(posedge clk)
   begin
      if (cmd_pop)
         cmd_q <= cmd;
      case (state)
         INIT:
         begin
            end_addr <= cmd_q.addr + cmd_q.len;
            cur_addr <= {cmd_q.addr[AW-1:LS], {LS{1'b0}}};
         end
         PAGE:
         begin
            next_page <= {cur_addr[AW-1:PS], {PS{1'b0}}} + AW'(`MEMCPY_PAGE_BYTES);
            end_page  <= (end_addr[PS-1:0] == '0) ? end_addr :
                         {end_addr[AW-1:PS] + 1'b1, {PS{1'b0}}};
            end_line  <= (end_addr[LS-1:0] == '0) ? end_addr :
                         {end_addr[AW-1:LS] + 1'b1, {LS{1'b0}}};
         end
         SIZE:
         begin
            if (beyond_page)
               cur_lines <= 8'(`MEMCPY_MAX_BURST) - 8'(cur_addr[PS-1:LS]);
            else
               cur_lines <= line_span[LS+7:LS];
         end
         START:
         begin
            burst.addr  <= cur_addr;
            burst.lines <= cur_lines;
         end
         DONE:
         begin
            // the next burst picks up right at the page edge.
            if (!last_burst)
               cur_addr <= next_page;
         end
         default:
         begin
         end
      endcase
   end

   // ========================================
   // checks
   // ========================================
   assign burst_last_line = burst.addr + (AW'(burst.lines - 8'd1) << LS);

   a_burst_lines: assert property (
      @(posedge clk) disable iff (!rst_n)
      burst_start |-> (burst.lines >= 8'd1) && (burst.lines <= 8'(`MEMCPY_MAX_BURST))
   ) else $error("burst line count out of range");

   a_burst_page: assert property (
      @(posedge clk) disable iff (!rst_n)
      burst_start |-> (burst_last_line[AW-1:PS] == burst.addr[AW-1:PS])
   ) else $error("burst crosses a page boundary");

endmodule

/* memcpy_burst_reader.sv */
`include "memcpy_consts.svh"

module memcpy_burst_reader (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      burst_start,
   input  memcpy_pkg::burst_req_t    burst,
   output logic                      mem_req,
   output memcpy_pkg::burst_req_t    mem_burst,
   input  logic                      mem_rvalid,
   input  logic [`MEMCPY_DATA_W-1:0] mem_rdata,
   output logic                      line_push,
   output memcpy_pkg::line_t         line_out,
   output logic                      burst_done
);

   localparam int AW = `MEMCPY_ADDR_W;

   logic          busy;
   logic [7:0]    beats_left;
   logic [AW-1:0] line_addr;
   logic          last_push;

   // ========================================
   // control
   // ========================================
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         busy       <= 1'b0;
         beats_left <= '0;
         mem_req    <= 1'b0;
         line_push  <= 1'b0;
         last_push  <= 1'b0;
         burst_done <= 1'b0;
      end
      else
      begin
         mem_req    <= burst_start;
         line_push  <= mem_rvalid;
         // last_push rides along with the final line push.
         last_push  <= mem_rvalid && (beats_left == 8'd1);
         burst_done <= last_push;
         if (burst_start)
         begin
            busy       <= 1'b1;
            beats_left <= burst.lines;
         end
         else
         begin
            if (mem_rvalid)
               beats_left <= beats_left - 8'd1;
            if (burst_done)
               busy <= 1'b0;
         end
      end
   end

   // ========================================
   // payload
   // ========================================
   always_ff @(posedge clk)
   begin
      if (burst_start)
      begin
         mem_burst <= burst;
         line_addr <= burst.addr;
      end
      else if (mem_rvalid)
         line_addr <= line_addr + AW'(`MEMCPY_LINE_BYTES);
      if (mem_rvalid)
      begin
         line_out.addr <= line_addr;
         line_out.data <= mem_rdata;
      end
   end

   // beats belong to the request this reader made.
   a_rvalid_expected: assert property (
      @(posedge clk) disable iff (!rst_n)
      mem_rvalid |-> (beats_left != 8'd0)
   ) else $error("memory beat with no beats outstanding");

   a_start_idle: assert property (
      @(posedge clk) disable iff (!rst_n)
      burst_start |-> !busy
   ) else $error("burst started while the reader was busy");

endmodule

/* memcpy_top.sv */
`include "memcpy_consts.svh"

module memcpy_top (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      cmd_push,
   input  memcpy_pkg::copy_cmd_t     cmd,
   output logic                      cmd_full,
   output logic                      mem_req,
   output memcpy_pkg::burst_req_t    mem_burst,
   input  logic                      mem_rvalid,
   input  logic [`MEMCPY_DATA_W-1:0] mem_rdata,
   output logic                      line_valid,
   output memcpy_pkg::line_t         line,
   input  logic                      line_pop,
   output logic                      copy_done
);

   localparam int FREE_W = $clog2(`MEMCPY_LINE_DEPTH) + 1;

   logic                   cmd_empty;
   memcpy_pkg::copy_cmd_t  cmd_head;
   logic                   cmd_pop;
   logic                   buf_busy;
   logic                   burst_start;
   memcpy_pkg::burst_req_t burst;
   logic                   burst_done;
   logic                   line_push;
   memcpy_pkg::line_t      line_in;
   logic                   line_empty;
   logic [FREE_W-1:0]      line_free;

   // a burst may only start when a whole page of lines still fits.
   assign buf_busy   = (line_free < FREE_W'(`MEMCPY_MAX_BURST));
   assign line_valid = !line_empty;

   memcpy_sync_fifo #(.payload_t(memcpy_pkg::copy_cmd_t), .DEPTH(`MEMCPY_CMD_DEPTH)) cmd_queue_i (
      .clk, .rst_n,
      .push(cmd_push), .wdata(cmd), .pop(cmd_pop), .rdata(cmd_head),
      .empty(cmd_empty), .full(cmd_full), .free()
   );

   memcpy_burst_planner planner_i (
      .clk, .rst_n,
      .cmd_empty, .cmd(cmd_head), .cmd_pop, .buf_busy,
      .burst_start, .burst, .burst_done, .copy_done
   );

   memcpy_burst_reader reader_i (
      .clk, .rst_n,
      .burst_start, .burst, .mem_req, .mem_burst, .mem_rvalid, .mem_rdata,
      .line_push, .line_out(line_in), .burst_done
   );

   memcpy_sync_fifo #(.payload_t(memcpy_pkg::line_t), .DEPTH(`MEMCPY_LINE_DEPTH)) line_buf_i (
      .clk, .rst_n,
      .push(line_push), .wdata(line_in), .pop(line_pop), .rdata(line),
      .empty(line_empty), .full(), .free(line_free)
   );

endmodule

/* memcpy_tb.sv */
`include "memcpy_consts.svh"

module memcpy_tb;

   localparam logic [63:0] PATTERN = 64'hA5A5_5A5A_0F0F_F0F0;
   localparam int          NCMD    = 20;

   logic                      clk = 1'b0;
   logic                      rst_n;
   logic                      cmd_push;
   memcpy_pkg::copy_cmd_t     cmd;
   logic                      cmd_full;
   logic                      mem_req;
   memcpy_pkg::burst_req_t    mem_burst;
   logic                      mem_rvalid;
   logic [`MEMCPY_DATA_W-1:0] mem_rdata;
   logic                      line_valid;
   memcpy_pkg::line_t         line;
   logic                      line_pop;
   logic                      copy_done;

   integer      seed;
   int          errors = 0;
   int          cycles = 0;
   int          limit = 0;
   string       test_name = "reset";
   logic [63:0] addrs [NCMD];
   logic [63:0] lens [NCMD];
   logic [63:0] exp_q [$];
   logic [63:0] req_q [$];
   logic [63:0] burst_q [$];
   int          burst_lines_q [$];
   logic [63:0] exp_addr = '0;
   logic [63:0] req_next = '0;
   logic [63:0] beat_addr = '0;
   logic [63:0] burst_last;
   int          beats_left = 0;
   int          q_cnt = 0;
   int          unpushed = 0;
   int          push_lines = 0;
   logic        stall_pop = 1'b0;
   logic        zero_test = 1'b0;
   logic        full_seen = 1'b0;
   logic        busy_seen = 1'b0;

   memcpy_top dut_i (
      .clk, .rst_n, .cmd_push, .cmd, .cmd_full, .mem_req, .mem_burst, .mem_rvalid,
      .mem_rdata, .line_valid, .line, .line_pop, .copy_done
   );

   always #10 clk = ~clk;

   // lines from the start rounded down to the end rounded up, both to a line.
   function automatic int line_count(input logic [63:0] addr, input logic [63:0] len);
      logic [63:0] first;
      logic [63:0] last;
      first = {addr[63:6], 6'd0};
      last  = addr + len + 64'd63;
      last  = {last[63:6], 6'd0};
      return (len == '0) ? 0 : int'((last - first) >> 6);
   endfunction

   task automatic report_mismatch(input string what, input logic [63:0] expected,
                                  input logic [63:0] actual);
      errors++;
      $display("MISMATCH %s %s expected %h actual %h", test_name, what, expected, actual);
   endtask

   task automatic report_fault(input string msg);
      errors++;
      $display("ERROR in %s: %s", test_name, msg);
   endtask

   task automatic send_cmd(input int i);
      int n;
      n = line_count(addrs[i], lens[i]);
      @(posedge clk);
      #2;
      while (cmd_full)
      begin
         @(posedge clk);
         #2;
      end
      cmd_push   = 1'b1;
      cmd.addr   = addrs[i];
      cmd.len    = lens[i];
      push_lines = n;
      for (int k = 0; k < n; k++)
      begin
         exp_q.push_back({addrs[i][63:6], 6'd0} + (64'(k) << 6));
         req_q.push_back({addrs[i][63:6], 6'd0} + (64'(k) << 6));
      end
      @(posedge clk);
      #2;
      cmd_push = 1'b0;
   endtask

   // waits until every line is consumed and the line buffer is empty.
   task automatic drain();
      @(negedge clk);
      while (!(copy_done && exp_q.size() == 0 && !line_valid))
         @(negedge clk);
   endtask

   // ========================================
   // memory model, consumer and counters
   // ========================================
   always @(posedge clk)
   begin
      #2;
      if (cmd_full)
         full_seen = 1'b1;
      if (stall_pop && dut_i.buf_busy)
         busy_seen = 1'b1;
      if (mem_req)
      begin
         burst_q.push_back(mem_burst.addr);
         burst_lines_q.push_back(int'(mem_burst.lines));
         req_next = (req_q.size() > 0) ? req_q[0] : '1;
         for (int k = 0; k < int'(mem_burst.lines) && req_q.size() > 0; k++)
            void'(req_q.pop_front());
      end
      if (beats_left == 0 && burst_q.size() > 0)
      begin
         beat_addr  = burst_q.pop_front();
         beats_left = burst_lines_q.pop_front();
      end
      mem_rvalid = 1'b0;
      if (beats_left > 0 && ($unsigned($random(seed)) % 4) != 0)
      begin
         mem_rvalid = 1'b1;
         mem_rdata  = beat_addr ^ PATTERN;
         beat_addr  = beat_addr + 64'd64;
         beats_left--;
      end
      line_pop = 1'b0;
      if (line_valid && !stall_pop && ($unsigned($random(seed)) % 8) != 0)
      begin
         line_pop = 1'b1;
         if (exp_q.size() > 0)
            exp_addr = exp_q.pop_front();
         else
            report_fault("a line was popped while no line was expected");
      end
   end

   always @(posedge clk)
   begin
      q_cnt    <= q_cnt + int'(cmd_push) - int'(dut_i.cmd_pop);
      unpushed <= unpushed + (cmd_push ? push_lines : 0) - int'(dut_i.line_push);
      cycles++;
      if (cycles > limit)
      begin
         $display("timeout after %0d cycles, %0d errors, %0d lines never arrived",
                  cycles, errors, exp_q.size());
         $display("Errors found");
         $finish;
      end
   end

   // ========================================
   // checks
   // ========================================
   assign burst_last = mem_burst.addr + ((64'(mem_burst.lines) - 64'd1) << 6);

   a_line_addr: assert property (@(posedge clk) disable iff (!rst_n)
      line_pop |-> line.addr == exp_addr)
   else report_mismatch("line address", $sampled(exp_addr), $sampled(line.addr));

   a_line_data: assert property (@(posedge clk) disable iff (!rst_n)
      line_pop |-> line.data == (exp_addr ^ PATTERN))
   else report_mismatch("line data", $sampled(exp_addr) ^ PATTERN, $sampled(line.data));

   a_burst_addr: assert property (@(posedge clk) disable iff (!rst_n)
      mem_req |-> mem_burst.addr == req_next)
   else report_mismatch("burst address", $sampled(req_next), $sampled(mem_burst.addr));

   a_burst_shape: assert property (@(posedge clk) disable iff (!rst_n)
      mem_req |-> mem_burst.lines >= 8'd1 && mem_burst.lines <= 8'(`MEMCPY_MAX_BURST) &&
                  mem_burst.addr[5:0] == 6'd0 && burst_last[63:12] == mem_burst.addr[63:12])
   else report_fault("a burst is misaligned, has a bad length or crosses a 4 KB page");

   a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
      stall_pop && dut_i.buf_busy |-> !mem_req)
   else report_fault("a memory request was issued while the line buffer lacked room");

   a_zero_len: assert property (@(posedge clk) disable iff (!rst_n)
      zero_test |-> !mem_req && !line_valid)
   else report_fault("the zero-length command produced a request or a line");

   a_cmd_full: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_full == (q_cnt == `MEMCPY_CMD_DEPTH))
   else report_mismatch("cmd_full", 64'($sampled(q_cnt) == 4), 64'($sampled(cmd_full)));

   a_copy_done: assert property (@(posedge clk) disable iff (!rst_n)
      copy_done |-> q_cnt == 0 && unpushed == 0)
   else report_fault("copy_done was high while work was still pending");

   // ========================================
   // stimulus
   // ========================================
   initial
   begin
      seed = 32'hcf617e59;
      rst_n = 1'b0;
      cmd_push = 1'b0;
      cmd = '0;
      mem_rvalid = 1'b0;
      mem_rdata = '0;
      line_pop = 1'b0;
      addrs[0] = 64'h1000;
      lens[0] = 64'd64;
      addrs[1] = 64'h2013;
      lens[1] = 64'd10;
      addrs[2] = 64'h3FC8;
      lens[2] = 64'h80;
      addrs[3] = 64'h5F10;
      lens[3] = 64'h3123;
      addrs[4] = 64'h7008;
      lens[4] = 64'd0;
      addrs[5] = 64'h10000;
      lens[5] = 64'h3000;
      addrs[6] = 64'h20000;
      lens[6] = 64'h20C8;
      for (int i = 7; i < 11; i++)
      begin
         addrs[i] = 64'h40018 + 64'(i) * 64'h1100;
         lens[i]  = 64'd500 + 64'(i) * 64'd37;
      end
      for (int i = 11; i < NCMD; i++)
      begin
         addrs[i] = 64'($unsigned($random(seed))) & 64'hF_FFFF;
         lens[i]  = 64'($unsigned($random(seed)) % 9000);
      end
      for (int i = 0; i < NCMD; i++)
         limit += 40 * line_count(addrs[i], lens[i]) + 200;
      repeat (8) @(posedge clk);
      #2;
      rst_n = 1'b1;
      test_name = "directed";
      for (int i = 0; i < 4; i++)
         send_cmd(i);
      drain();
      test_name = "zero_length";
      zero_test = 1'b1;
      send_cmd(4);
      drain();
      zero_test = 1'b0;
      test_name = "back_pressure";
      stall_pop = 1'b1;
      send_cmd(5);
      repeat (600) @(negedge clk);
      stall_pop = 1'b0;
      drain();
      test_name = "queue";
      for (int i = 6; i < 11; i++)
         send_cmd(i);
      drain();
      test_name = "random";
      for (int i = 11; i < NCMD; i++)
         send_cmd(i);
      drain();
      repeat (4) @(posedge clk);
      if (!full_seen)
         report_fault("cmd_full never rose with four commands pending");
      if (!busy_seen)
         report_fault("the line buffer never filled while popping was stalled");
      if (req_q.size() != 0)
         report_fault("some expected lines were never requested from memory");
      $display("summary: %0d errors over %0d commands in %0d cycles", errors, NCMD, cycles);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

/* filelist.f */
+incdir+.
memcpy_pkg.sv
memcpy_sync_fifo.sv
memcpy_burst_planner.sv
memcpy_burst_reader.sv
memcpy_top.sv
memcpy_tb.sv

/* Bender.yml */
package:
  name: memcpy_read

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - memcpy_pkg.sv
      - memcpy_sync_fifo.sv
      - memcpy_burst_planner.sv
      - memcpy_burst_reader.sv
      - memcpy_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - memcpy_tb.sv
